//--- src/mem_settings.svh
// ----------------------------------------------------------
// Memory subsystem settings
// Word geometry, SRAM latency and response buffering depth
// ----------------------------------------------------------

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Word address width, 256 words per bank
`define MEM_ADDR_WIDTH 8

// Data word width, a whole number of bytes
`define MEM_DATA_WIDTH 32

// Cycles from an accepted SRAM request to its response strobe
`define MEM_LATENCY 2

// Outstanding request limit
// Also sizes the response buffer and the port index FIFO
`define RESP_BUF_DEPTH 2

`endif

//--- src/mem_pkg.sv
// ----------------------------------------------------------
// Memory payload types
// Request and response structs shared by adapter and SRAM
// ----------------------------------------------------------

`include "mem_settings.svh"

package mem_pkg;

  // Number of byte lanes in one word
  localparam int unsigned StrbWidth = `MEM_DATA_WIDTH / 8;

  typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`MEM_DATA_WIDTH-1:0] data_t;
  typedef logic [StrbWidth-1:0]       strb_t;

  // One memory request
  // Byte enables only matter on writes
  typedef struct packed {
    logic  we;
    addr_t addr;
    strb_t strb;
    data_t wdata;
  } mem_req_t;

  // One memory response
  // Writes return the word after the merge
  typedef struct packed {
    data_t rdata;
  } mem_resp_t;

endpackage

//--- src/port_pkg.sv
// ----------------------------------------------------------
// Requester port types
// Port count and the index used to steer responses
// ----------------------------------------------------------

package port_pkg;

  // Number of requester ports on the subsystem
  localparam int unsigned NumPorts = 2;

  // Width of a port index, kept at least one bit
  localparam int unsigned PortIdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  // Selects one requester port
  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // Port that wins arbitration right after reset
  localparam port_idx_t FirstPort = '0;

  // Port treated as granted last after reset
  // Hands first priority to FirstPort
  localparam port_idx_t ResetLastPort = port_idx_t'(NumPorts - 1);

endpackage

//--- src/mem_bus_if.sv
// ----------------------------------------------------------
// Memory-side bus between adapter and SRAM bank
// Valid/ready requests, strobed responses
// ----------------------------------------------------------
`timescale 1ns/10ps

interface mem_bus_if;
  import mem_pkg::*;

  // Request channel, transfers on valid and ready
  mem_req_t  req;
  logic      req_valid;
  logic      req_ready;

  // Response channel
  // One-cycle strobe, no back-pressure
  mem_resp_t resp;
  logic      resp_valid;

  // Adapter side, issues requests and takes responses
  modport host (
    output req,
    output req_valid,
    input  req_ready,
    input  resp,
    input  resp_valid
  );

  // SRAM side
  modport device (
    input  req,
    input  req_valid,
    output req_ready,
    output resp,
    output resp_valid
  );

endinterface

//--- src/stream_fifo.sv
// ----------------------------------------------------------
// Valid/ready FIFO for any payload type
// Circular buffer, optional fall-through when empty
// ----------------------------------------------------------
`timescale 1ns/10ps

module stream_fifo #(
  parameter type         T            = logic,
  parameter int unsigned DEPTH        = 2,
  parameter bit          FALL_THROUGH = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  T                             data_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  output T                             data_o,
  output logic                         valid_o,
  input  logic                         ready_i,
  output logic [$clog2(DEPTH+1)-1:0]   usage_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  // Storage has no reset, only pointers and fill count do
  T                mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            empty;
  logic            full;
  logic            bypass;
  logic            push;
  logic            pop;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == CntW'(DEPTH));

  // Empty fall-through FIFO forwards its input directly
  assign bypass = FALL_THROUGH & empty & valid_i;

  assign valid_o = ~empty | bypass;
  assign data_o  = bypass ? data_i : mem_q[rd_ptr_q];

  // Full FIFO still takes a word when the head leaves this cycle
  assign ready_o = ~full | ready_i;

  // Bypassed word consumed at once never touches storage
  assign push = valid_i & ready_o & ~(bypass & ready_i);
  assign pop  = valid_o & ready_i & ~bypass;

  assign usage_o = cnt_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap at DEPTH, so any depth works
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- src/stream_to_mem.sv
// ----------------------------------------------------------
// Stream to memory adapter
// Bounds outstanding requests, buffers strobed responses
// ----------------------------------------------------------
`timescale 1ns/10ps

module stream_to_mem #(
  parameter type         mem_req_t  = logic,
  parameter type         mem_resp_t = logic,
  parameter int unsigned BufDepth   = 1
) (
  input  logic      clk_i,
  input  logic      rst_i,
  // Request stream in
  input  mem_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  // Response stream out
  output mem_resp_t resp_o,
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  // Memory side
  mem_bus_if.host   mem
);

  // One extra bit so the count never wraps at BufDepth
  typedef logic [$clog2(BufDepth+1):0] cnt_t;

  cnt_t cnt_d;
  cnt_t cnt_q;
  logic active_q;
  logic req_xfer;
  logic resp_xfer;
  logic req_ready;

  assign req_xfer  = req_valid_i & req_ready_o;
  assign resp_xfer = resp_valid_o & resp_ready_i;

  // Outstanding count
  // Up on each accepted request, down on each delivered response
  always_comb begin
    cnt_d = cnt_q;
    if (req_xfer) begin
      cnt_d = cnt_d + 1'b1;
    end
    if (resp_xfer) begin
      cnt_d = cnt_d - 1'b1;
    end
  end

  // Room for another request, or one slot freed this very cycle
  // Held off for the first cycle out of reset
  assign req_ready = active_q & ((cnt_q < cnt_t'(BufDepth)) | resp_xfer);

  assign req_ready_o   = mem.req_ready & req_ready;
  assign mem.req_valid = req_valid_i & req_ready;
  assign mem.req       = req_i;

  // Fall-through buffer, a response can leave in its arrival cycle
  // Never overflows, the count reserves a slot per request
  stream_fifo #(
    .T            (mem_resp_t),
    .DEPTH        (BufDepth),
    .FALL_THROUGH (1'b1)
  ) u_resp_buf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (mem.resp),
    .valid_i (mem.resp_valid),
    .ready_o (),
    .data_o  (resp_o),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .usage_o ()
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      active_q <= 1'b1;
    end
  end

endmodule

//--- src/sram_bank.sv
// ----------------------------------------------------------
// Byte-enabled SRAM bank
// Fixed-latency, fully pipelined responses
// ----------------------------------------------------------
`timescale 1ns/10ps

`include "mem_settings.svh"

module sram_bank (
  input  logic      clk_i,
  input  logic      rst_i,
  mem_bus_if.device mem
);
  import mem_pkg::*;

  localparam int unsigned NumWords = 2 ** `MEM_ADDR_WIDTH;

  data_t                   mem_q [NumWords];
  data_t                   old_word;
  data_t                   new_word;
  logic                    req_xfer;
  // Response pipeline, stage MEM_LATENCY-1 drives the bus
  logic [`MEM_LATENCY-1:0] valid_q;
  data_t                   data_q [`MEM_LATENCY];

  // Bank never stalls
  assign mem.req_ready = 1'b1;
  assign req_xfer      = mem.req_valid & mem.req_ready;

  assign old_word = mem_q[mem.req.addr];

  // Merge enabled bytes of a write into the stored word
  // Reads see the stored word unchanged
  always_comb begin
    new_word = old_word;
    if (mem.req.we) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (mem.req.strb[b]) begin
          new_word[b*8 +: 8] = mem.req.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer && mem.req.we) begin
      mem_q[mem.req.addr] <= new_word;
    end
  end

  // Data stages carry payload only
  always_ff @(posedge clk_i) begin
    data_q[0] <= new_word;
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req_xfer;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign mem.resp.rdata = data_q[`MEM_LATENCY-1];
  assign mem.resp_valid = valid_q[`MEM_LATENCY-1];

endmodule

//--- src/req_resp_mux.sv
// ----------------------------------------------------------
// Round-robin request merge with ordered response return
// Index FIFO remembers the issuing port of each request
// ----------------------------------------------------------
`timescale 1ns/10ps

`include "mem_settings.svh"

module req_resp_mux (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Requester side
  input  mem_pkg::mem_req_t                   port_req_i        [port_pkg::NumPorts],
  input  logic [port_pkg::NumPorts-1:0]       port_req_valid_i,
  output logic [port_pkg::NumPorts-1:0]       port_req_ready_o,
  output mem_pkg::mem_resp_t                  port_resp_o       [port_pkg::NumPorts],
  output logic [port_pkg::NumPorts-1:0]       port_resp_valid_o,
  input  logic [port_pkg::NumPorts-1:0]       port_resp_ready_i,
  // Merged side, towards the adapter
  output mem_pkg::mem_req_t                   req_o,
  output logic                                req_valid_o,
  input  logic                                req_ready_i,
  input  mem_pkg::mem_resp_t                  resp_i,
  input  logic                                resp_valid_i,
  output logic                                resp_ready_o
);
  import port_pkg::*;

  port_idx_t last_q;
  port_idx_t lock_idx_q;
  logic      lock_q;
  port_idx_t arb_idx;
  port_idx_t cand;
  logic      arb_found;
  port_idx_t grant;
  logic      req_xfer;
  port_idx_t head_idx;
  logic      head_valid;
  logic      resp_xfer;

  // Search starts one past the last winner
  always_comb begin
    arb_idx   = last_q;
    arb_found = 1'b0;
    cand      = last_q;
    for (int i = 1; i <= NumPorts; i++) begin
      cand = port_idx_t'((int'(last_q) + i) % NumPorts);
      if (!arb_found && port_req_valid_i[cand]) begin
        arb_idx   = cand;
        arb_found = 1'b1;
      end
    end
  end

  // Stalled grant is held so the merged payload stays stable
  assign grant = lock_q ? lock_idx_q : arb_idx;

  assign req_o       = port_req_i[grant];
  assign req_valid_o = port_req_valid_i[grant];
  assign req_xfer    = req_valid_o & req_ready_i;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      port_req_ready_o[p] = (grant == port_idx_t'(p)) & req_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q     <= ResetLastPort;
      lock_q     <= 1'b0;
      lock_idx_q <= FirstPort;
    end else begin
      if (req_xfer) begin
        last_q <= grant;
      end
      lock_q     <= req_valid_o & ~req_ready_i;
      lock_idx_q <= grant;
    end
  end

  // Issuing port of every accepted request, oldest at the head
  // Depth matches the adapter's outstanding limit
  stream_fifo #(
    .T            (port_idx_t),
    .DEPTH        (`RESP_BUF_DEPTH),
    .FALL_THROUGH (1'b0)
  ) u_idx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (grant),
    .valid_i (req_xfer),
    .ready_o (),
    .data_o  (head_idx),
    .valid_o (head_valid),
    .ready_i (resp_xfer),
    .usage_o ()
  );

  // Responses come back in order, the head names their owner
  assign resp_ready_o = head_valid & port_resp_ready_i[head_idx];
  assign resp_xfer    = resp_valid_i & resp_ready_o;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      port_resp_o[p]       = resp_i;
      port_resp_valid_o[p] = resp_valid_i & head_valid & (head_idx == port_idx_t'(p));
    end
  end

endmodule

//--- src/mem_subsys_top.sv
// ----------------------------------------------------------
// Two-port SRAM access subsystem
// Arbiter, stream to memory adapter and SRAM bank
// ----------------------------------------------------------
`timescale 1ns/10ps

`include "mem_settings.svh"

module mem_subsys_top (
  input  logic            clk_i,
  input  logic            rst_i,
  // Port 0
  input  logic            p0_req_we_i,
  input  mem_pkg::addr_t  p0_req_addr_i,
  input  mem_pkg::strb_t  p0_req_strb_i,
  input  mem_pkg::data_t  p0_req_wdata_i,
  input  logic            p0_req_valid_i,
  output logic            p0_req_ready_o,
  output mem_pkg::data_t  p0_resp_rdata_o,
  output logic            p0_resp_valid_o,
  input  logic            p0_resp_ready_i,
  // Port 1
  input  logic            p1_req_we_i,
  input  mem_pkg::addr_t  p1_req_addr_i,
  input  mem_pkg::strb_t  p1_req_strb_i,
  input  mem_pkg::data_t  p1_req_wdata_i,
  input  logic            p1_req_valid_i,
  output logic            p1_req_ready_o,
  output mem_pkg::data_t  p1_resp_rdata_o,
  output logic            p1_resp_valid_o,
  input  logic            p1_resp_ready_i
);
  import mem_pkg::*;
  import port_pkg::*;

  mem_req_t            port_req        [NumPorts];
  mem_resp_t           port_resp       [NumPorts];
  logic [NumPorts-1:0] port_req_valid;
  logic [NumPorts-1:0] port_req_ready;
  logic [NumPorts-1:0] port_resp_valid;
  logic [NumPorts-1:0] port_resp_ready;

  // Merged stream between arbiter and adapter
  mem_req_t            mux_req;
  logic                mux_req_valid;
  logic                mux_req_ready;
  mem_resp_t           mux_resp;
  logic                mux_resp_valid;
  logic                mux_resp_ready;

  // Pack per-port pins into request structs
  assign port_req[0] = '{we: p0_req_we_i, addr: p0_req_addr_i,
                         strb: p0_req_strb_i, wdata: p0_req_wdata_i};
  assign port_req[1] = '{we: p1_req_we_i, addr: p1_req_addr_i,
                         strb: p1_req_strb_i, wdata: p1_req_wdata_i};

  assign port_req_valid  = {p1_req_valid_i, p0_req_valid_i};
  assign port_resp_ready = {p1_resp_ready_i, p0_resp_ready_i};

  assign p0_req_ready_o  = port_req_ready[0];
  assign p1_req_ready_o  = port_req_ready[1];
  assign p0_resp_rdata_o = port_resp[0].rdata;
  assign p1_resp_rdata_o = port_resp[1].rdata;
  assign p0_resp_valid_o = port_resp_valid[0];
  assign p1_resp_valid_o = port_resp_valid[1];

  mem_bus_if u_mem_bus ();

  req_resp_mux u_req_resp_mux (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .port_req_i        (port_req),
    .port_req_valid_i  (port_req_valid),
    .port_req_ready_o  (port_req_ready),
    .port_resp_o       (port_resp),
    .port_resp_valid_o (port_resp_valid),
    .port_resp_ready_i (port_resp_ready),
    .req_o             (mux_req),
    .req_valid_o       (mux_req_valid),
    .req_ready_i       (mux_req_ready),
    .resp_i            (mux_resp),
    .resp_valid_i      (mux_resp_valid),
    .resp_ready_o      (mux_resp_ready)
  );

  stream_to_mem #(
    .mem_req_t  (mem_req_t),
    .mem_resp_t (mem_resp_t),
    .BufDepth   (`RESP_BUF_DEPTH)
  ) u_stream_to_mem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (mux_req),
    .req_valid_i  (mux_req_valid),
    .req_ready_o  (mux_req_ready),
    .resp_o       (mux_resp),
    .resp_valid_o (mux_resp_valid),
    .resp_ready_i (mux_resp_ready),
    .mem          (u_mem_bus.host)
  );

  sram_bank u_sram_bank (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .mem   (u_mem_bus.device)
  );

endmodule

//--- test/mem_subsys_assertions.sv
// ----------------------------------------------------------
// Protocol assertions for the two-port memory subsystem
// Response buffer room, outstanding bound, payload stability
// ----------------------------------------------------------
`timescale 1ns/10ps

`include "mem_settings.svh"

module mem_subsys_assertions (
  input logic                                  clk_i,
  input logic                                  rst_i,
  input logic                                  mem_resp_valid_i,
  input logic                                  resp_buf_full_i,
  input logic [$clog2(`RESP_BUF_DEPTH+1):0]    outstanding_i,
  input mem_pkg::mem_req_t                     req_i,
  input logic                                  req_valid_i,
  input logic                                  req_ready_i
);

  // Failed assertions, read back at the end of the run
  int unsigned error_count = 0;

  // SRAM strobe has no back-pressure, buffer must have room
  a_resp_room: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_resp_valid_i |-> !resp_buf_full_i)
    else begin
      error_count = error_count + 1;
      $error("SRAM response arrived while the response buffer was full");
    end

  a_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    outstanding_i <= `RESP_BUF_DEPTH)
    else begin
      error_count = error_count + 1;
      $error("Outstanding request count above the buffer depth");
    end

  // Merged request held steady until the adapter takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_i)))
    else begin
      error_count = error_count + 1;
      $error("Merged request changed or dropped while stalled");
    end

endmodule

bind mem_subsys_top mem_subsys_assertions u_assertions (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .mem_resp_valid_i (u_mem_bus.resp_valid),
  .resp_buf_full_i  (u_stream_to_mem.u_resp_buf.full),
  .outstanding_i    (u_stream_to_mem.cnt_q),
  .req_i            (mux_req),
  .req_valid_i      (mux_req_valid),
  .req_ready_i      (mux_req_ready)
);

//--- test/tb_mem_subsys.sv
// ----------------------------------------------------------
// Testbench for the two-port memory subsystem
// Directed tests against a scoreboard model of the SRAM
// ----------------------------------------------------------
`timescale 1ns/10ps

`include "mem_settings.svh"

module tb_mem_subsys;
  import mem_pkg::*;
  import port_pkg::*;

  localparam int ContentionLen = 8;
  localparam int PreloadLen    = 32;
  localparam int RandomLen     = 200;
  // Requests over all tests, sizes the watchdog
  localparam int NumRequests   = 2 + 3 + 2 * ContentionLen + 5 + PreloadLen + RandomLen;

  logic                clk_i;
  logic                rst_i;
  logic                req_we    [NumPorts];
  addr_t               req_addr  [NumPorts];
  strb_t               req_strb  [NumPorts];
  data_t               req_wdata [NumPorts];
  logic [NumPorts-1:0] req_valid;
  logic [NumPorts-1:0] req_ready;
  data_t               resp_rdata [NumPorts];
  logic [NumPorts-1:0] resp_valid;
  logic [NumPorts-1:0] resp_ready;

  // Scoreboard state
  data_t       model [2**`MEM_ADDR_WIDTH];
  mem_req_t    stim_q [NumPorts][$];
  data_t       exp_q  [NumPorts][$];
  port_idx_t   order_q [$];
  logic        req_acc [NumPorts];
  logic        hold_low [NumPorts];
  bit          random_stall;
  port_idx_t   last_grant;
  // Merged request offered but not taken in the last cycle
  // The grant then stays on the stalled port
  bit          merged_stall;
  int          accepted_total;
  int          contended_grants;

  mem_subsys_top UUT (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .p0_req_we_i     (req_we[0]),
    .p0_req_addr_i   (req_addr[0]),
    .p0_req_strb_i   (req_strb[0]),
    .p0_req_wdata_i  (req_wdata[0]),
    .p0_req_valid_i  (req_valid[0]),
    .p0_req_ready_o  (req_ready[0]),
    .p0_resp_rdata_o (resp_rdata[0]),
    .p0_resp_valid_o (resp_valid[0]),
    .p0_resp_ready_i (resp_ready[0]),
    .p1_req_we_i     (req_we[1]),
    .p1_req_addr_i   (req_addr[1]),
    .p1_req_strb_i   (req_strb[1]),
    .p1_req_wdata_i  (req_wdata[1]),
    .p1_req_valid_i  (req_valid[1]),
    .p1_req_ready_o  (req_ready[1]),
    .p1_resp_rdata_o (resp_rdata[1]),
    .p1_resp_valid_o (resp_valid[1]),
    .p1_resp_ready_i (resp_ready[1])
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_port(string name, port_idx_t got, port_idx_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic mem_req_t make_req(logic we, addr_t addr, strb_t strb, data_t wdata);
    return '{we: we, addr: addr, strb: strb, wdata: wdata};
  endfunction

  // Enabled byte lanes replace the stored bytes
  function automatic data_t merge_bytes(data_t old_word, mem_req_t r);
    data_t w;
    w = old_word;
    for (int b = 0; b < `MEM_DATA_WIDTH / 8; b++) begin
      if (r.strb[b]) begin
        w[b*8 +: 8] = r.wdata[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // Stimulus drivers, payload held until the handshake
  always @(posedge clk_i) begin : drive_ports
    mem_req_t nxt;
    if (rst_i) begin
      req_valid  <= '0;
      resp_ready <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (!req_valid[p] || req_acc[p]) begin
          if (stim_q[p].size() > 0) begin
            nxt = stim_q[p].pop_front();
            req_we[p]    <= nxt.we;
            req_addr[p]  <= nxt.addr;
            req_strb[p]  <= nxt.strb;
            req_wdata[p] <= nxt.wdata;
            req_valid[p] <= 1'b1;
          end else begin
            req_valid[p] <= 1'b0;
          end
        end
        if (hold_low[p]) begin
          resp_ready[p] <= 1'b0;
        end else if (random_stall) begin
          resp_ready[p] <= ($urandom_range(3) != 0);
        end else begin
          resp_ready[p] <= 1'b1;
        end
      end
    end
  end

  // Sampled mid-cycle, a handshake seen here completes at the next edge
  always @(negedge clk_i) begin : watch_ports
    mem_req_t r;
    bit       any_acc;
    if (rst_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        req_acc[p] = 1'b0;
      end
      // Port 1 counts as last winner so port 0 goes first
      last_grant   = port_idx_t'(NumPorts - 1);
      merged_stall = 1'b0;
    end else begin
      any_acc = 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        req_acc[p] = req_valid[p] & req_ready[p];
        if (req_acc[p]) begin
          any_acc = 1'b1;
          // Round robin only decides when no stalled request holds the grant
          if (&req_valid && !merged_stall) begin
            check_port("granted port", port_idx_t'(p), port_idx_t'(last_grant + 1'b1));
            contended_grants++;
          end
          last_grant = port_idx_t'(p);
          r = make_req(req_we[p], req_addr[p], req_strb[p], req_wdata[p]);
          if (r.we) begin
            model[r.addr] = merge_bytes(model[r.addr], r);
          end
          exp_q[p].push_back(model[r.addr]);
          order_q.push_back(port_idx_t'(p));
          accepted_total++;
        end
        if (resp_valid[p] && resp_ready[p]) begin
          if (exp_q[p].size() == 0) begin
            $display("Port %0d returned a response with no request outstanding", p);
            abort_run();
          end
          check_port("responding port", port_idx_t'(p), order_q.pop_front());
          check_data($sformatf("p%0d_resp_rdata_o", p), resp_rdata[p], exp_q[p].pop_front());
        end
      end
      merged_stall = (|req_valid) & ~any_acc;
    end
  end

  // Bound checker failures end the run at once
  always @(negedge clk_i) begin : watch_assertions
    if (UUT.u_assertions.error_count != 0) begin
      $display("Protocol assertion failed at %0t", $time);
      abort_run();
    end
  end

  function automatic bit traffic_busy();
    bit busy;
    busy = |req_valid;
    for (int p = 0; p < NumPorts; p++) begin
      busy = busy | (stim_q[p].size() > 0) | (exp_q[p].size() > 0);
    end
    return busy;
  endfunction

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (traffic_busy());
  endtask

  // Outputs stay quiet in the first cycle out of reset
  task automatic check_reset_outputs();
    @(negedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      check_flag($sformatf("p%0d_req_ready_o", p), req_ready[p], 1'b0);
      check_flag($sformatf("p%0d_resp_valid_o", p), resp_valid[p], 1'b0);
    end
  endtask

  task automatic single_port_test();
    @(negedge clk_i);
    stim_q[0].push_back(make_req(1'b1, 8'h05, '1, data_t'($urandom)));
    stim_q[0].push_back(make_req(1'b0, 8'h05, '0, '0));
    wait_idle();
  endtask

  task automatic byte_enable_test();
    @(negedge clk_i);
    stim_q[0].push_back(make_req(1'b1, 8'h0a, '1, data_t'($urandom)));
    stim_q[0].push_back(make_req(1'b1, 8'h0a, 4'b0101, data_t'($urandom)));
    stim_q[0].push_back(make_req(1'b0, 8'h0a, '0, '0));
    wait_idle();
  endtask

  // Each port writes then reads its own words, both always valid
  task automatic contention_test();
    int start;
    addr_t a;
    @(negedge clk_i);
    start = contended_grants;
    for (int i = 0; i < ContentionLen / 2; i++) begin
      a = addr_t'(8'h10 + i);
      stim_q[0].push_back(make_req(1'b1, a, '1, data_t'($urandom)));
      stim_q[0].push_back(make_req(1'b0, a, '0, '0));
      a = addr_t'(8'h18 + i);
      stim_q[1].push_back(make_req(1'b1, a, '1, data_t'($urandom)));
      stim_q[1].push_back(make_req(1'b0, a, '0, '0));
    end
    wait_idle();
    check_flag("grants under contention", (contended_grants - start) >= ContentionLen, 1'b1);
  endtask

  task automatic backpressure_test();
    int start;
    @(negedge clk_i);
    hold_low[0] = 1'b1;
    start = accepted_total;
    for (int i = 0; i < 3; i++) begin
      stim_q[0].push_back(make_req(1'b0, addr_t'(8'h10 + i), '0, '0));
    end
    while (accepted_total < start + `RESP_BUF_DEPTH) begin
      @(negedge clk_i);
    end
    // Port 1 asks too, but the stalled head blocks everyone
    for (int i = 0; i < 2; i++) begin
      stim_q[1].push_back(make_req(1'b0, addr_t'(8'h18 + i), '0, '0));
    end
    repeat (`MEM_LATENCY + 2) @(negedge clk_i);
    check_flag("p0_req_ready_o", req_ready[0], 1'b0);
    check_flag("p1_req_ready_o", req_ready[1], 1'b0);
    hold_low[0] = 1'b0;
    wait_idle();
  endtask

  // Window is preloaded so no read sees an unwritten word
  task automatic random_test();
    int p;
    @(negedge clk_i);
    for (int i = 0; i < PreloadLen; i++) begin
      stim_q[0].push_back(make_req(1'b1, addr_t'(8'h40 + i), '1, data_t'($urandom)));
    end
    wait_idle();
    random_stall = 1'b1;
    for (int i = 0; i < RandomLen; i++) begin
      p = $urandom % NumPorts;
      stim_q[p].push_back(make_req(1'($urandom), addr_t'(8'h40 + ($urandom % PreloadLen)),
                                   strb_t'($urandom), data_t'($urandom)));
    end
    wait_idle();
    random_stall = 1'b0;
  endtask

  initial begin : watchdog
    repeat (16 + NumRequests * 20) @(posedge clk_i);
    $display("Watchdog expired before all traffic drained");
    $display("ERRORS FOUND");
    $fatal(1, "Timeout");
  end

  initial begin
    void'($urandom(32'h901c));
    rst_i            = 1'b1;
    req_valid        = '0;
    resp_ready       = '0;
    random_stall     = 1'b0;
    accepted_total   = 0;
    contended_grants = 0;
    for (int p = 0; p < NumPorts; p++) begin
      req_we[p]    = 1'b0;
      req_addr[p]  = '0;
      req_strb[p]  = '0;
      req_wdata[p] = '0;
      req_acc[p]   = 1'b0;
      hold_low[p]  = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    check_reset_outputs();
    single_port_test();
    byte_enable_test();
    contention_test();
    backpressure_test();
    random_test();
    if (UUT.u_assertions.error_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "Protocol assertions failed");
    end
  end

endmodule

//--- filelist.f
+incdir+src
src/mem_pkg.sv
src/port_pkg.sv
src/mem_bus_if.sv
src/stream_fifo.sv
src/stream_to_mem.sv
src/sram_bank.sv
src/req_resp_mux.sv
src/mem_subsys_top.sv
test/mem_subsys_assertions.sv
test/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - src

sources:
  - src/mem_pkg.sv
  - src/port_pkg.sv
  - src/mem_bus_if.sv
  - src/stream_fifo.sv
  - src/stream_to_mem.sv
  - src/sram_bank.sv
  - src/req_resp_mux.sv
  - src/mem_subsys_top.sv
  - target: test
    files:
      - test/mem_subsys_assertions.sv
      - test/tb_mem_subsys.sv
